// File: logic/frontend_pkg.sv
// Front-end adapter shared definitions
// Converter and core word widths, default channel and peripheral counts

package frontend_pkg;

   // Converter side
   parameter int ADC_WIDTH = 12;       // ADC output word
   parameter int DAC_WIDTH = 12;       // DAC input bus

   // Core side
   parameter int SAMPLE_WIDTH = 14;    // Receive sample into the DSP
   parameter int CORE_DAC_WIDTH = 16;  // Transmit word from the DSP

   // Default counts, overridden from the top level when needed
   parameter int NUM_RX_CH = 2;
   parameter int NUM_SPI_DEV = 9;

   // Raw word as it comes off one ADC bus
   typedef logic [ADC_WIDTH-1:0] adc_word_t;

   // Receive sample after zero extension
   typedef logic [SAMPLE_WIDTH-1:0] sample_t;

   // Core transmit word, only the low DAC_WIDTH bits reach the pins
   typedef logic [CORE_DAC_WIDTH-1:0] core_dac_t;

   // Word on the shared I/Q DAC bus
   typedef logic [DAC_WIDTH-1:0] dac_code_t;

endpackage : frontend_pkg

// File: logic/rx_iq_deinterleave.sv
// Receive I/Q deinterleaver
// Splits time-interleaved ADC buses into I/Q pairs, widens them and strobes each pair

`timescale 1ns/1ps

module rx_iq_deinterleave
#(
   parameter int NUM_RX_CH = frontend_pkg::NUM_RX_CH
)
(
   input  logic                                      dsp_clk,
   input  logic                                      reset_i,

   // Converter side
   input  frontend_pkg::adc_word_t [NUM_RX_CH-1:0]   adc_data_i,
   output logic                                      rx_iq_sel_o,

   // Core side
   output frontend_pkg::sample_t   [NUM_RX_CH-1:0]   rx_i_o,
   output frontend_pkg::sample_t   [NUM_RX_CH-1:0]   rx_q_o,
   output logic                                      rx_strobe_o
);

   import frontend_pkg::*;

   localparam int PAD_W = SAMPLE_WIDTH - ADC_WIDTH;

   logic      q_cycle;                  // 0 on I cycles, 1 on Q cycles
   adc_word_t i_hold [NUM_RX_CH];       // I word waiting for its Q partner

   // Unsigned converter codes, so upper bits are zero
   function automatic sample_t widen(input adc_word_t word);
      return {{PAD_W{1'b0}}, word};
   endfunction

   // Phase toggles every cycle and is driven out as the IQ select
   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
      begin
         q_cycle <= 1'b0;
      end
      else
      begin
         q_cycle <= ~q_cycle;
      end
   end

   assign rx_iq_sel_o = q_cycle;

   // I capture
   always_ff @(posedge dsp_clk)
   begin
      if (!q_cycle)
      begin
         for (int ch = 0; ch < NUM_RX_CH; ch++)
         begin
            i_hold[ch] <= adc_data_i[ch];
         end
      end
   end

   // Pair register, loaded on the Q edge
   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
      begin
         rx_i_o      <= '0;
         rx_q_o      <= '0;
         rx_strobe_o <= 1'b0;
      end
      else
      begin
         rx_strobe_o <= q_cycle;            // One cycle per finished pair
         if (q_cycle)
         begin
            for (int ch = 0; ch < NUM_RX_CH; ch++)
            begin
               rx_i_o[ch] <= widen(i_hold[ch]);
               rx_q_o[ch] <= widen(adc_data_i[ch]);   // Q straight from the bus
            end
         end
      end
   end

   // Pair strobe never lasts longer than one cycle
   a_strobe_single: assert property (
      @(posedge dsp_clk) disable iff (reset_i)
      rx_strobe_o |=> !rx_strobe_o
   );

   // Strobe lands in the I cycle that follows the Q edge
   a_strobe_after_q: assert property (
      @(posedge dsp_clk) disable iff (reset_i)
      rx_strobe_o |-> !rx_iq_sel_o
   );

endmodule : rx_iq_deinterleave

// File: logic/tx_iq_interleave.sv
// Transmit I/Q interleaver
// Alternates core I and Q words onto the single DAC bus with a matching select

`timescale 1ns/1ps

module tx_iq_interleave
(
   input  logic                    dsp_clk,
   input  logic                    reset_i,

   // Core side, held levels
   input  frontend_pkg::core_dac_t tx_i_i,
   input  frontend_pkg::core_dac_t tx_q_i,

   // Converter side
   output frontend_pkg::dac_code_t dac_o,
   output logic                    tx_iq_sel_o
);

   import frontend_pkg::*;

   logic q_phase;       // Half being loaded at the next edge

   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
      begin
         q_phase     <= 1'b0;
         dac_o       <= '0;
         tx_iq_sel_o <= 1'b0;
      end
      else
      begin
         // Low bits only, the converter is narrower than the core
         if (q_phase)
         begin
            dac_o <= tx_q_i[DAC_WIDTH-1:0];
         end
         else
         begin
            dac_o <= tx_i_i[DAC_WIDTH-1:0];
         end
         tx_iq_sel_o <= q_phase;        // Flags which half dac_o holds
         q_phase     <= ~q_phase;
      end
   end

   // Select alternates once the first word has been loaded
   a_sel_alternates: assert property (
      @(posedge dsp_clk) disable iff (reset_i)
      (!$past(reset_i) && !$past(reset_i, 2)) |-> (tx_iq_sel_o != $past(tx_iq_sel_o))
   );

endmodule : tx_iq_interleave

// File: logic/spi_fanout.sv
// SPI fan-out
// Gates the shared serial clock and data per peripheral and merges read data back

`timescale 1ns/1ps

module spi_fanout
#(
   parameter int NUM_SPI_DEV = frontend_pkg::NUM_SPI_DEV
)
(
   input  logic                   dsp_clk,
   input  logic                   reset_i,

   // Core side
   input  logic                   spi_sclk_i,
   input  logic                   spi_mosi_i,
   input  logic [NUM_SPI_DEV-1:0] spi_sen_n_i,     // Active low enables
   output logic                   spi_miso_o,

   // Peripheral side
   output logic [NUM_SPI_DEV-1:0] dev_sclk_o,
   output logic [NUM_SPI_DEV-1:0] dev_mosi_o,
   input  logic [NUM_SPI_DEV-1:0] dev_miso_i
);

   logic [NUM_SPI_DEV-1:0] dev_sel;

   assign dev_sel = ~spi_sen_n_i;

   // Idle peripherals see a quiet bus
   assign dev_sclk_o = {NUM_SPI_DEV{spi_sclk_i}} & dev_sel;
   assign dev_mosi_o = {NUM_SPI_DEV{spi_mosi_i}} & dev_sel;

   // Deselected peripherals may float their MISO, so mask before merging
   assign spi_miso_o = |(dev_miso_i & dev_sel);

   // Two enabled peripherals would fight on the merged read line
   a_one_enable: assert property (
      @(posedge dsp_clk) disable iff (reset_i)
      $onehot0(dev_sel)
   );

endmodule : spi_fanout

// File: logic/frontend_top.sv
// Radio front-end adapter top level
// Receive deinterleave, transmit interleave and SPI fan-out side by side on dsp_clk

`timescale 1ns/1ps

module frontend_top
#(
   parameter int NUM_RX_CH   = frontend_pkg::NUM_RX_CH,
   parameter int NUM_SPI_DEV = frontend_pkg::NUM_SPI_DEV
)
(
   input  logic                                      dsp_clk,
   input  logic                                      reset_i,

   // ADC buses, I and Q interleaved in time
   input  frontend_pkg::adc_word_t [NUM_RX_CH-1:0]   adc_data_i,
   output logic                                      rx_iq_sel_o,

   // Receive pairs toward the DSP core
   output frontend_pkg::sample_t   [NUM_RX_CH-1:0]   rx_i_o,
   output frontend_pkg::sample_t   [NUM_RX_CH-1:0]   rx_q_o,
   output logic                                      rx_strobe_o,

   // Transmit words from the DSP core
   input  frontend_pkg::core_dac_t                   tx_i_i,
   input  frontend_pkg::core_dac_t                   tx_q_i,

   // DAC bus
   output frontend_pkg::dac_code_t                   dac_o,
   output logic                                      tx_iq_sel_o,

   // Core SPI master
   input  logic                                      spi_sclk_i,
   input  logic                                      spi_mosi_i,
   input  logic [NUM_SPI_DEV-1:0]                    spi_sen_n_i,
   output logic                                      spi_miso_o,

   // SPI peripherals
   output logic [NUM_SPI_DEV-1:0]                    dev_sclk_o,
   output logic [NUM_SPI_DEV-1:0]                    dev_mosi_o,
   input  logic [NUM_SPI_DEV-1:0]                    dev_miso_i
);

   // Receive path
   rx_iq_deinterleave
   #(
      .NUM_RX_CH   (NUM_RX_CH)
   )
   u_rx_iq_deinterleave
   (
      .dsp_clk     (dsp_clk),
      .reset_i     (reset_i),
      .adc_data_i  (adc_data_i),
      .rx_iq_sel_o (rx_iq_sel_o),
      .rx_i_o      (rx_i_o),
      .rx_q_o      (rx_q_o),
      .rx_strobe_o (rx_strobe_o)
   );

   // Transmit path
   tx_iq_interleave u_tx_iq_interleave
   (
      .dsp_clk     (dsp_clk),
      .reset_i     (reset_i),
      .tx_i_i      (tx_i_i),
      .tx_q_i      (tx_q_i),
      .dac_o       (dac_o),
      .tx_iq_sel_o (tx_iq_sel_o)
   );

   // SPI path, combinational apart from its enable check
   spi_fanout
   #(
      .NUM_SPI_DEV (NUM_SPI_DEV)
   )
   u_spi_fanout
   (
      .dsp_clk     (dsp_clk),
      .reset_i     (reset_i),
      .spi_sclk_i  (spi_sclk_i),
      .spi_mosi_i  (spi_mosi_i),
      .spi_sen_n_i (spi_sen_n_i),
      .spi_miso_o  (spi_miso_o),
      .dev_sclk_o  (dev_sclk_o),
      .dev_mosi_o  (dev_mosi_o),
      .dev_miso_i  (dev_miso_i)
   );

endmodule : frontend_top

// File: tb/tb_frontend_top.sv
// Testbench for the radio front-end adapter
// Random converter, core and SPI stimulus checked against a cycle model of the phase rules

`timescale 1ns/1ps

module tb_frontend_top;

   import frontend_pkg::*;

   localparam logic [31:0] SEED = 32'hc98379d8;
   localparam int RESET_CYCLES   = 16;
   localparam int RUN_CYCLES     = 2000;
   localparam int TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 4;

   logic                           dsp_clk = 1'b0;
   logic                           reset_i;
   adc_word_t [NUM_RX_CH-1:0]      adc_data_i;
   logic                           rx_iq_sel_o;
   sample_t   [NUM_RX_CH-1:0]      rx_i_o;
   sample_t   [NUM_RX_CH-1:0]      rx_q_o;
   logic                           rx_strobe_o;
   core_dac_t                      tx_i_i;
   core_dac_t                      tx_q_i;
   dac_code_t                      dac_o;
   logic                           tx_iq_sel_o;
   logic                           spi_sclk_i;
   logic                           spi_mosi_i;
   logic      [NUM_SPI_DEV-1:0]    spi_sen_n_i;
   logic                           spi_miso_o;
   logic      [NUM_SPI_DEV-1:0]    dev_sclk_o;
   logic      [NUM_SPI_DEV-1:0]    dev_mosi_o;
   logic      [NUM_SPI_DEV-1:0]    dev_miso_i;

   // Reference model state, valid after the most recent rising edge
   logic      m_rx_phase;
   adc_word_t m_i_hold [NUM_RX_CH];
   sample_t   m_rx_i [NUM_RX_CH];
   sample_t   m_rx_q [NUM_RX_CH];
   logic      m_rx_strobe;
   logic      m_tx_phase;
   dac_code_t m_dac;
   logic      m_tx_sel;

   int   spi_pick;                 // Enabled peripheral, NUM_SPI_DEV when none
   int   cycle_count = 0;
   int   strobe_count = 0;
   int   last_strobe_cyc = 0;
   logic prev_rx_sel;
   logic prev_tx_sel;

   frontend_top
   #(
      .NUM_RX_CH   (NUM_RX_CH),
      .NUM_SPI_DEV (NUM_SPI_DEV)
   )
   DUT
   (
      .dsp_clk     (dsp_clk),
      .reset_i     (reset_i),
      .adc_data_i  (adc_data_i),
      .rx_iq_sel_o (rx_iq_sel_o),
      .rx_i_o      (rx_i_o),
      .rx_q_o      (rx_q_o),
      .rx_strobe_o (rx_strobe_o),
      .tx_i_i      (tx_i_i),
      .tx_q_i      (tx_q_i),
      .dac_o       (dac_o),
      .tx_iq_sel_o (tx_iq_sel_o),
      .spi_sclk_i  (spi_sclk_i),
      .spi_mosi_i  (spi_mosi_i),
      .spi_sen_n_i (spi_sen_n_i),
      .spi_miso_o  (spi_miso_o),
      .dev_sclk_o  (dev_sclk_o),
      .dev_mosi_o  (dev_mosi_o),
      .dev_miso_i  (dev_miso_i)
   );

   initial
   begin
      forever
      begin
         #2 dsp_clk = ~dsp_clk;     // 4 ns period
      end
   end

   always @(posedge dsp_clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         abort_run();
      end
   end

   task automatic abort_run();
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped at the first failure");
   endtask

   // Registered outputs against the model, sampled mid-cycle
   task automatic check_registered(input int cyc);
      assert (rx_strobe_o === m_rx_strobe && rx_iq_sel_o === m_rx_phase) else
      begin
         $display("ERROR @%0t: cycle %0d rx strobe/sel %b/%b, expected %b/%b", $time, cyc,
                  rx_strobe_o, rx_iq_sel_o, m_rx_strobe, m_rx_phase);
         abort_run();
      end
      for (int ch = 0; ch < NUM_RX_CH; ch++)
      begin
         assert (rx_i_o[ch] === m_rx_i[ch] && rx_q_o[ch] === m_rx_q[ch]) else
         begin
            $display("ERROR @%0t: channel %0d pair I=%h Q=%h, expected I=%h Q=%h", $time, ch,
                     rx_i_o[ch], rx_q_o[ch], m_rx_i[ch], m_rx_q[ch]);
            abort_run();
         end
      end
      assert (dac_o === m_dac && tx_iq_sel_o === m_tx_sel) else
      begin
         $display("ERROR @%0t: cycle %0d dac_o=%h sel=%b, expected dac_o=%h sel=%b", $time,
                  cyc, dac_o, tx_iq_sel_o, m_dac, m_tx_sel);
         abort_run();
      end
   endtask

   // Everything quiet while reset is applied
   task automatic check_reset_values(input int cyc);
      assert (rx_strobe_o === 1'b0 && rx_iq_sel_o === 1'b0 && tx_iq_sel_o === 1'b0 &&
              dac_o === '0 && rx_i_o === '0 && rx_q_o === '0) else
      begin
         $display("ERROR @%0t: cycle %0d outputs not cleared by reset", $time, cyc);
         abort_run();
      end
   endtask

   task automatic check_phase_patterns(input int cyc);
      assert (rx_iq_sel_o !== prev_rx_sel) else
      begin
         $display("ERROR @%0t: cycle %0d rx_iq_sel_o did not toggle", $time, cyc);
         abort_run();
      end
      // First transmit edge after reset loads phase 0 again
      if (cyc > RESET_CYCLES + 1)
      begin
         assert (tx_iq_sel_o !== prev_tx_sel) else
         begin
            $display("ERROR @%0t: cycle %0d tx_iq_sel_o did not toggle", $time, cyc);
            abort_run();
         end
      end
      if (rx_strobe_o)
      begin
         assert (last_strobe_cyc == 0 || cyc - last_strobe_cyc == 2) else
         begin
            $display("ERROR @%0t: strobe gap of %0d cycles, expected 2", $time,
                     cyc - last_strobe_cyc);
            abort_run();
         end
         last_strobe_cyc = cyc;
         strobe_count++;
      end
   endtask

   // Combinational SPI outputs, expected per peripheral
   task automatic check_spi();
      logic [NUM_SPI_DEV-1:0] exp_sclk;
      logic [NUM_SPI_DEV-1:0] exp_mosi;
      logic                   exp_miso;
      for (int d = 0; d < NUM_SPI_DEV; d++)
      begin
         exp_sclk[d] = spi_sen_n_i[d] ? 1'b0 : spi_sclk_i;
         exp_mosi[d] = spi_sen_n_i[d] ? 1'b0 : spi_mosi_i;
      end
      exp_miso = 1'b0;
      if (spi_pick < NUM_SPI_DEV)
      begin
         exp_miso = dev_miso_i[spi_pick];
      end
      assert (dev_sclk_o === exp_sclk && dev_mosi_o === exp_mosi &&
              spi_miso_o === exp_miso) else
      begin
         $display("ERROR @%0t: SPI sclk=%b mosi=%b miso=%b, expected %b %b %b", $time,
                  dev_sclk_o, dev_mosi_o, spi_miso_o, exp_sclk, exp_mosi, exp_miso);
         abort_run();
      end
   endtask

   task automatic drive_inputs(input int cyc);
      logic [31:0] rnd;
      reset_i = (cyc < RESET_CYCLES);
      for (int ch = 0; ch < NUM_RX_CH; ch++)
      begin
         rnd = $urandom();
         adc_data_i[ch] = rnd[ADC_WIDTH-1:0];
      end
      rnd = $urandom();
      if (rnd[1:0] == 2'd0)                  // Core words change now and then
      begin
         tx_i_i = rnd[31:16];
      end
      rnd = $urandom();
      if (rnd[1:0] == 2'd0)
      begin
         tx_q_i = rnd[31:16];
      end
      spi_pick = $urandom() % (NUM_SPI_DEV + 1);
      for (int d = 0; d < NUM_SPI_DEV; d++)
      begin
         spi_sen_n_i[d] = (d != spi_pick);
      end
      rnd = $urandom();
      spi_sclk_i = rnd[0];
      spi_mosi_i = rnd[1];
      dev_miso_i = rnd[NUM_SPI_DEV+1:2];
   endtask

   // Model state after the coming rising edge
   task automatic update_model();
      if (reset_i)
      begin
         for (int ch = 0; ch < NUM_RX_CH; ch++)
         begin
            m_rx_i[ch] = '0;
            m_rx_q[ch] = '0;
         end
         m_rx_strobe = 1'b0;
         m_rx_phase  = 1'b0;
         m_tx_phase  = 1'b0;
         m_dac       = '0;
         m_tx_sel    = 1'b0;
      end
      else
      begin
         for (int ch = 0; ch < NUM_RX_CH; ch++)
         begin
            if (m_rx_phase)
            begin
               m_rx_i[ch] = {{(SAMPLE_WIDTH-ADC_WIDTH){1'b0}}, m_i_hold[ch]};
               m_rx_q[ch] = {{(SAMPLE_WIDTH-ADC_WIDTH){1'b0}}, adc_data_i[ch]};
            end
            else
            begin
               m_i_hold[ch] = adc_data_i[ch];     // I half of the next pair
            end
         end
         m_rx_strobe = m_rx_phase;
         m_rx_phase  = ~m_rx_phase;
         m_dac       = m_tx_phase ? tx_q_i[DAC_WIDTH-1:0] : tx_i_i[DAC_WIDTH-1:0];
         m_tx_sel    = m_tx_phase;
         m_tx_phase  = ~m_tx_phase;
      end
   endtask

   initial
   begin
      void'($urandom(SEED));
      reset_i     = 1'b1;
      adc_data_i  = '0;
      tx_i_i      = '0;
      tx_q_i      = '0;
      spi_sclk_i  = 1'b0;
      spi_mosi_i  = 1'b0;
      spi_sen_n_i = '1;
      dev_miso_i  = '0;
      spi_pick    = NUM_SPI_DEV;
      prev_rx_sel = 1'b0;
      prev_tx_sel = 1'b0;
      for (int ch = 0; ch < NUM_RX_CH; ch++)
      begin
         m_i_hold[ch] = '0;
      end
      update_model();                        // First edge sees reset high

      for (int cyc = 1; cyc <= RUN_CYCLES; cyc++)
      begin
         @(negedge dsp_clk);
         check_registered(cyc);
         if (cyc <= RESET_CYCLES)
         begin
            check_reset_values(cyc);
         end
         else
         begin
            check_phase_patterns(cyc);
         end
         prev_rx_sel = rx_iq_sel_o;
         prev_tx_sel = tx_iq_sel_o;
         drive_inputs(cyc);
         update_model();
         #1;
         check_spi();
      end

      // One pair every second cycle once reset is released
      if (strobe_count == (RUN_CYCLES - RESET_CYCLES) / 2)
      begin
         $display("TEST PASSED");
         $finish;
      end
      else
      begin
         $display("ERROR @%0t: %0d pair strobes, expected %0d", $time, strobe_count,
                  (RUN_CYCLES - RESET_CYCLES) / 2);
         abort_run();
      end
   end

endmodule : tb_frontend_top

// File: compile.f
logic/frontend_pkg.sv
logic/rx_iq_deinterleave.sv
logic/tx_iq_interleave.sv
logic/spi_fanout.sv
logic/frontend_top.sv
tb/tb_frontend_top.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the front-end adapter testbench

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_frontend_top \
   -o sim_frontend_top && ./obj_dir/sim_frontend_top | tee sim.log

# The log decides, the simulator exit code alone is not trusted
grep -q "^TEST PASSED$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
